//--- kbd_config.svh
`ifndef KBD_CONFIG_SVH
`define KBD_CONFIG_SVH

// ==================================================
// Keyboard receiver build constants
// ==================================================

// Scan codes held in the FIFO
`define KBD_FIFO_DEPTH      8

// Idle cycles allowed between PS/2 bits
`define KBD_TIMEOUT_CYCLES  10000

// Flip-flops per synchronized PS/2 line
`define KBD_SYNC_STAGES     3

`define KBD_CODE_BITS       8   // One scan code byte
`define KBD_BUS_BITS        16  // Register bus data

`endif

//--- kbd_pkg.sv
`include "kbd_config.svh"

package kbd_pkg;

    // ==================================================
    // Data types
    // ==================================================

    typedef logic [`KBD_CODE_BITS-1:0] scan_code_t;  // One received byte
    typedef logic [`KBD_BUS_BITS-1:0]  bus_data_t;   // Bus read/write data

    // Offsets not listed here are unmapped
    typedef enum logic [3:0] {
        REG_RAW     = 4'h1,  // Pops the head code
        REG_STATUS  = 4'h2,
        REG_CONTROL = 4'h3   // Write only
    } reg_offset_t;

    // ==================================================
    // Register bit positions
    // ==================================================

    // Status register
    localparam int STAT_AVAIL    = 0;  // FIFO holds a code
    localparam int STAT_FULL     = 1;
    localparam int STAT_OVERFLOW = 2;  // Code lost since last pop

    // Control register
    localparam int CTRL_CLEAR_BIT = 0;  // Write 1 to empty the FIFO

endpackage

//--- ps2_sync.sv
`timescale 1ns/1ps
`include "kbd_config.svh"

module ps2_sync (
    input  logic clk,
    input  logic reset,
    input  logic ps2_clk_pin,
    input  logic ps2_data_pin,
    output logic ps2_fall,
    output logic ps2_bit
);

    localparam int STAGES = `KBD_SYNC_STAGES;

    logic [STAGES-1:0] clk_sync;   // Bit 0 nearest the pin
    logic [STAGES-1:0] data_sync;

    // Both lines idle high, so no false edge out of reset
    always_ff @(posedge clk) begin
        if (reset) begin
            clk_sync  <= '1;
            data_sync <= '1;
        end else begin
            clk_sync  <= {clk_sync[STAGES-2:0], ps2_clk_pin};
            data_sync <= {data_sync[STAGES-2:0], ps2_data_pin};
        end
    end

    // High-to-low on the last two clock stages
    assign ps2_fall = clk_sync[STAGES-1] & ~clk_sync[STAGES-2];

    // Data delayed as far as the clock, so it lines up with the edge
    assign ps2_bit = data_sync[STAGES-1];

endmodule

//--- ps2_frame_rx.sv
`timescale 1ns/1ps
`include "kbd_config.svh"

module ps2_frame_rx #(
    parameter int TIMEOUT_CYCLES = `KBD_TIMEOUT_CYCLES
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               ps2_fall,
    input  logic               ps2_bit,
    output logic               code_valid,
    output kbd_pkg::scan_code_t code
);

    import kbd_pkg::*;

    localparam int TW = $clog2(TIMEOUT_CYCLES + 1);

    typedef enum logic [2:0] {
        IDLE,
        START,
        DATA,
        PARITY,
        STOP,
        VALIDATE
    } rx_state_t;

    rx_state_t  state;
    rx_state_t  next_state;
    logic [2:0] bit_cnt;      // Data bits taken so far
    logic [TW-1:0] timer;     // Cycles since last falling edge
    logic       timed_out;
    scan_code_t shift_reg;
    logic       parity_bit;
    logic       stop_bit;
    logic       parity_ok;

    assign timed_out = (timer == TW'(TIMEOUT_CYCLES));
    assign parity_ok = ^{parity_bit, shift_reg};  // Odd count of ones

    // ==================================================
    // Next state
    // ==================================================

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (ps2_fall && !ps2_bit) begin  // Start bit is a zero
                    next_state = START;
                end
            end
            START: begin
                next_state = DATA;
            end
            DATA: begin
                if (ps2_fall) begin
                    if (bit_cnt == 3'd7) begin
                        next_state = PARITY;
                    end
                end else if (timed_out) begin
                    next_state = IDLE;
                end
            end
            PARITY: begin
                if (ps2_fall) begin
                    next_state = STOP;
                end else if (timed_out) begin
                    next_state = IDLE;
                end
            end
            STOP: begin
                if (ps2_fall) begin
                    next_state = VALIDATE;
                end else if (timed_out) begin
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = IDLE;  // VALIDATE lasts one cycle
            end
        endcase
    end

    // ==================================================
    // Control registers
    // ==================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= IDLE;
            bit_cnt    <= '0;
            timer      <= '0;
            code_valid <= 1'b0;
        end else begin
            state      <= next_state;
            code_valid <= (state == VALIDATE) && stop_bit && parity_ok;

            if (state == DATA && ps2_fall) begin
                bit_cnt <= bit_cnt + 3'd1;
            end else if (state != DATA) begin
                bit_cnt <= '0;
            end

            // Timer only runs while waiting for a frame bit
            if (state inside {DATA, PARITY, STOP} && !ps2_fall) begin
                timer <= timer + TW'(1);
            end else begin
                timer <= '0;
            end
        end
    end

    // Frame payload
    always_ff @(posedge clk) begin
        if (ps2_fall) begin
            case (state)
                DATA:    shift_reg  <= {ps2_bit, shift_reg[$bits(scan_code_t)-1:1]};
                PARITY:  parity_bit <= ps2_bit;
                STOP:    stop_bit   <= ps2_bit;
                default: ;
            endcase
        end
    end

    assign code = shift_reg;  // Held steady through the strobe

    // One strobe per frame
    a_single_strobe: assert property (
        @(posedge clk) disable iff (reset) code_valid |=> !code_valid
    );

endmodule

//--- scan_fifo.sv
`timescale 1ns/1ps
`include "kbd_config.svh"

module scan_fifo #(
    parameter int DEPTH = `KBD_FIFO_DEPTH
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                clear,
    input  logic                wr_valid,
    input  kbd_pkg::scan_code_t wr_code,
    output logic                rd_valid,
    input  logic                rd_ready,
    output kbd_pkg::scan_code_t rd_code,
    output logic                full,
    output logic                overflow
);

    import kbd_pkg::*;

    localparam int AW = $clog2(DEPTH);

    scan_code_t    mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;   // 0 to DEPTH
    logic          pop;
    logic          wr_en;

    assign rd_valid = (count != '0);
    assign full     = (count == (AW+1)'(DEPTH));
    assign rd_code  = mem[rd_ptr];
    assign pop      = rd_valid && rd_ready;
    assign wr_en    = wr_valid && (!full || pop);  // A pop frees the slot

    // ==================================================
    // Storage
    // ==================================================

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_code;
        end
    end

    // ==================================================
    // Pointers, count and overflow
    // ==================================================

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + AW'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + AW'(1);
            end

            if (wr_en && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !wr_valid) begin
                count    <= count - 1'b1;
                overflow <= 1'b0;  // Room again
            end else if (wr_valid && !wr_en) begin
                overflow <= 1'b1;  // Code dropped while full
            end
        end
    end

    a_count_bound: assert property (
        @(posedge clk) disable iff (reset) count <= (AW+1)'(DEPTH)
    );

    // Count tracks the distance between the pointers
    a_count_matches_ptrs: assert property (
        @(posedge clk) disable iff (reset) count[AW-1:0] == AW'(wr_ptr - rd_ptr)
    );

endmodule

//--- kbd_regs.sv
`timescale 1ns/1ps

module kbd_regs (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 device_select,
    input  logic                 read_req,
    input  logic                 write_req,
    input  kbd_pkg::reg_offset_t register_offset,
    input  kbd_pkg::bus_data_t   wdata,
    output kbd_pkg::bus_data_t   rdata,
    input  logic                 rd_valid,
    input  kbd_pkg::scan_code_t  rd_code,
    output logic                 rd_ready,
    input  logic                 full,
    input  logic                 overflow,
    output logic                 clear
);

    import kbd_pkg::*;

    logic bus_read;
    logic bus_write;

    assign bus_read  = device_select && read_req;
    assign bus_write = device_select && write_req;

    // Reading RAW pops; the FIFO ignores it when empty
    assign rd_ready = bus_read && (register_offset == REG_RAW);

    // ==================================================
    // Read mux
    // ==================================================

    always_comb begin
        rdata = '0;  // Not selected
        if (bus_read) begin
            case (register_offset)
                REG_RAW: begin
                    rdata = rd_valid ? bus_data_t'(rd_code) : '0;
                end
                REG_STATUS: begin
                    rdata[STAT_AVAIL]    = rd_valid;
                    rdata[STAT_FULL]     = full;
                    rdata[STAT_OVERFLOW] = overflow;
                end
                REG_CONTROL: begin
                    rdata = '0;  // Write only
                end
                default: begin
                    rdata = '1;  // Unmapped
                end
            endcase
        end
    end

    // One clear strobe cycle per control write
    always_ff @(posedge clk) begin
        if (reset) begin
            clear <= 1'b0;
        end else begin
            clear <= bus_write && (register_offset == REG_CONTROL)
                     && wdata[CTRL_CLEAR_BIT];
        end
    end

endmodule

//--- keyboard_controller.sv
`timescale 1ns/1ps

module keyboard_controller (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 device_select,
    input  kbd_pkg::reg_offset_t register_offset,
    input  logic                 read_req,
    input  logic                 write_req,
    input  kbd_pkg::bus_data_t   wdata,
    output kbd_pkg::bus_data_t   rdata,
    input  logic                 ps2_clk_pin,
    input  logic                 ps2_data_pin
);

    import kbd_pkg::*;

    logic       ps2_fall;
    logic       ps2_bit;
    logic       code_valid;
    scan_code_t code;
    logic       rd_valid;
    logic       rd_ready;
    scan_code_t rd_code;
    logic       full;
    logic       overflow;
    logic       clear;

    // ==================================================
    // PS/2 side
    // ==================================================

    ps2_sync ps2_sync_i (
        .clk          (clk),
        .reset        (reset),
        .ps2_clk_pin  (ps2_clk_pin),
        .ps2_data_pin (ps2_data_pin),
        .ps2_fall     (ps2_fall),
        .ps2_bit      (ps2_bit)
    );

    ps2_frame_rx ps2_frame_rx_i (
        .clk        (clk),
        .reset      (reset),
        .ps2_fall   (ps2_fall),
        .ps2_bit    (ps2_bit),
        .code_valid (code_valid),
        .code       (code)
    );

    // ==================================================
    // Buffer and bus side
    // ==================================================

    scan_fifo scan_fifo_i (
        .clk      (clk),
        .reset    (reset),
        .clear    (clear),
        .wr_valid (code_valid),  // Keyboard cannot be stalled
        .wr_code  (code),
        .rd_valid (rd_valid),
        .rd_ready (rd_ready),
        .rd_code  (rd_code),
        .full     (full),
        .overflow (overflow)
    );

    kbd_regs kbd_regs_i (
        .clk             (clk),
        .reset           (reset),
        .device_select   (device_select),
        .read_req        (read_req),
        .write_req       (write_req),
        .register_offset (register_offset),
        .wdata           (wdata),
        .rdata           (rdata),
        .rd_valid        (rd_valid),
        .rd_code         (rd_code),
        .rd_ready        (rd_ready),
        .full            (full),
        .overflow        (overflow),
        .clear           (clear)
    );

endmodule

//--- tb_keyboard_controller.sv
`timescale 1ns/1ps
`include "kbd_config.svh"

module tb_keyboard_controller;

    import kbd_pkg::*;

    localparam int PS2_HALF     = 8;                       // System clocks per PS/2 half bit
    localparam int FRAME_CYCLES = 11 * 2 * PS2_HALF + 16;  // Frame plus idle gap
    localparam int FRAME_COUNT  = 25;
    localparam int WATCHDOG_CYCLES =
        FRAME_COUNT * FRAME_CYCLES + `KBD_TIMEOUT_CYCLES + 100 + 4000;

    logic        clk = 1'b0;
    logic        reset;
    logic        device_select;
    reg_offset_t register_offset;
    logic        read_req;
    logic        write_req;
    bus_data_t   wdata;
    bus_data_t   rdata;
    logic        ps2_clk_pin;
    logic        ps2_data_pin;

    scan_code_t  model_q[$];   // Expected FIFO contents
    logic        model_ovf;
    logic        poll_mode;    // Status polls are not compared
    logic [31:0] lfsr_state = 32'h9e21_e877;
    int          errors;
    int          checks;
    int          test_start;

    keyboard_controller keyboard_controller_i (
        .clk             (clk),
        .reset           (reset),
        .device_select   (device_select),
        .register_offset (register_offset),
        .read_req        (read_req),
        .write_req       (write_req),
        .wdata           (wdata),
        .rdata           (rdata),
        .ps2_clk_pin     (ps2_clk_pin),
        .ps2_data_pin    (ps2_data_pin)
    );

    always #20 clk = ~clk;  // 40 ns period

    // ==================================================
    // Helpers
    // ==================================================

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_byte(output scan_code_t value);
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value[i]   = lfsr_state[0];
        end
    endtask

    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #2;  // Drive just after the edge
    endtask

    task automatic check_value(input bus_data_t actual, input bus_data_t expected,
                               input string msg);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0t: %s, got %h expected %h", $time, msg, actual, expected);
        end
    endtask

    // ==================================================
    // Reference model
    // ==================================================

    // Stop must be 1 and data plus parity must hold an odd count of ones
    function automatic bit frame_accepted(input scan_code_t data, input logic parity,
                                          input logic stop);
        return stop && (^{parity, data});
    endfunction

    function automatic bus_data_t expected_rdata(input logic [3:0] offset);
        bus_data_t r;
        r = '0;
        case (offset)
            4'h1: begin
                if (model_q.size() > 0) begin
                    r[7:0] = model_q[0];
                end
            end
            4'h2: begin
                r[STAT_AVAIL]    = (model_q.size() > 0);
                r[STAT_FULL]     = (model_q.size() == `KBD_FIFO_DEPTH);
                r[STAT_OVERFLOW] = model_ovf;
            end
            4'h3: r = '0;
            default: r = '1;  // Unmapped
        endcase
        return r;
    endfunction

    task automatic model_push(input scan_code_t data);
        if (model_q.size() < `KBD_FIFO_DEPTH) begin
            model_q.push_back(data);
        end else begin
            model_ovf = 1'b1;  // Dropped on a full FIFO
        end
    endtask

    // Every selected read is compared mid-cycle, where rdata has settled
    always @(negedge clk) begin : compare_reads
        bus_data_t exp_value;
        if (device_select && read_req && !poll_mode) begin
            exp_value = expected_rdata(register_offset);
            check_value(rdata, exp_value, $sformatf("read offset %0d", register_offset));
            if (register_offset == REG_RAW && model_q.size() > 0) begin
                void'(model_q.pop_front());
                model_ovf = 1'b0;
            end
        end
    end

    // ==================================================
    // Bus and PS/2 drivers
    // ==================================================

    task automatic read_reg(input logic [3:0] offset);
        device_select   = 1'b1;
        read_req        = 1'b1;
        register_offset = reg_offset_t'(offset);
        step(1);
        device_select = 1'b0;
        read_req      = 1'b0;
    endtask

    task automatic write_reg(input logic [3:0] offset, input bus_data_t data);
        device_select   = 1'b1;
        write_req       = 1'b1;
        register_offset = reg_offset_t'(offset);
        wdata           = data;
        step(1);
        device_select = 1'b0;
        write_req     = 1'b0;
        if (offset == REG_CONTROL && data[CTRL_CLEAR_BIT]) begin
            model_q.delete();
            model_ovf = 1'b0;
        end
    endtask

    // Poll status until a code is available
    task automatic wait_code();
        int tries;
        logic avail;
        tries = 0;
        avail = 1'b0;
        while (!avail && tries < 50) begin
            poll_mode       = 1'b1;
            device_select   = 1'b1;
            read_req        = 1'b1;
            register_offset = REG_STATUS;
            #10;
            avail = rdata[STAT_AVAIL];
            step(1);
            device_select = 1'b0;
            read_req      = 1'b0;
            poll_mode     = 1'b0;
            tries++;
        end
        if (!avail) begin
            errors++;
            $display("Status never showed a code available at %0t", $time);
        end
    endtask

    // data_bits below 8 cuts the frame after that many data bits
    task automatic send_frame(input scan_code_t data, input bit bad_parity,
                              input bit bad_stop, input int data_bits);
        logic [10:0] frame;
        logic        parity;
        int          n_bits;
        parity = ~(^data) ^ bad_parity;
        frame  = {~bad_stop, parity, data, 1'b0};  // Start bit sent first
        n_bits = (data_bits < 8) ? data_bits + 1 : 11;
        for (int i = 0; i < n_bits; i++) begin
            ps2_data_pin = frame[i];  // Changes while the clock is high
            step(PS2_HALF / 2);
            ps2_clk_pin = 1'b0;
            step(PS2_HALF);
            ps2_clk_pin = 1'b1;
            step(PS2_HALF / 2);
        end
        ps2_data_pin = 1'b1;
        step(16);
        if (data_bits == 8 && frame_accepted(data, parity, ~bad_stop)) begin
            model_push(data);
        end
    endtask

    task automatic send_random(input bit bad_parity, input bit bad_stop);
        scan_code_t b;
        random_byte(b);
        send_frame(b, bad_parity, bad_stop, 8);
    endtask

    task automatic end_test(input string name);
        $display("test %s: %0d errors", name, errors - test_start);
        test_start = errors;
    endtask

    // ==================================================
    // Tests
    // ==================================================

    initial begin : stimulus
        scan_code_t b;
        reset           = 1'b1;
        device_select   = 1'b0;
        register_offset = REG_STATUS;
        read_req        = 1'b0;
        write_req       = 1'b0;
        wdata           = '0;
        ps2_clk_pin     = 1'b1;
        ps2_data_pin    = 1'b1;
        model_ovf       = 1'b0;
        poll_mode       = 1'b0;
        errors          = 0;
        checks          = 0;
        test_start      = 0;
        step(8);
        reset = 1'b0;
        step(2);

        read_reg(REG_STATUS);
        read_reg(REG_RAW);
        read_reg(REG_CONTROL);
        end_test("reset values");

        repeat (6) send_random(1'b0, 1'b0);
        wait_code();
        repeat (6) read_reg(REG_RAW);
        read_reg(REG_STATUS);  // Available gone
        end_test("good frames in order");

        send_random(1'b0, 1'b0);
        send_random(1'b1, 1'b0);  // Bad parity
        send_random(1'b0, 1'b0);
        send_random(1'b0, 1'b1);  // Stop bit low
        send_random(1'b0, 1'b0);
        wait_code();
        repeat (3) read_reg(REG_RAW);
        read_reg(REG_STATUS);
        end_test("bad frames dropped");

        repeat (9) send_random(1'b0, 1'b0);
        wait_code();
        read_reg(REG_STATUS);  // Overflow, full, available
        read_reg(REG_RAW);
        read_reg(REG_STATUS);  // Overflow cleared by the pop
        repeat (7) read_reg(REG_RAW);
        read_reg(REG_STATUS);
        end_test("overflow");

        random_byte(b);
        send_frame(b, 1'b0, 1'b0, 3);
        step(`KBD_TIMEOUT_CYCLES + 100);  // Receiver gives up on the frame
        send_random(1'b0, 1'b0);
        wait_code();
        read_reg(REG_RAW);
        read_reg(REG_STATUS);
        end_test("frame timeout");

        repeat (3) send_random(1'b0, 1'b0);
        wait_code();
        read_reg(REG_STATUS);
        write_reg(REG_CONTROL, 16'h0001);
        step(2);
        read_reg(REG_STATUS);
        read_reg(REG_RAW);
        read_reg(4'h0);
        for (int off = 4; off < 16; off++) begin
            read_reg(4'(off));
        end
        end_test("clear and unmapped");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired, the tests did not finish in time");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- sim.f
+incdir+.
kbd_pkg.sv
ps2_sync.sv
ps2_frame_rx.sv
scan_fifo.sv
kbd_regs.sv
keyboard_controller.sv
tb_keyboard_controller.sv
